// File: rtl/cpuPkg.sv
package cpuPkg;

  typedef logic [3:0]  regIdT;    // Register number, 16 registers
  typedef logic [15:0] wordT;     // Data word held in registers and memory
  typedef logic [7:0]  memAddrT;  // Word address into the data memory

  // Instruction opcodes, carried in the top nibble of every instruction
  typedef enum logic [3:0] {
    ADD = 4'h0,
    SUB = 4'h1,
    AND = 4'h2,
    XOR = 4'h3,
    LDI = 4'h4,  // Load 8-bit immediate
    LW  = 4'h5,
    SW  = 4'h6,
    NOP = 4'hF
  } opcodeT;

  // Source of an EX operand as chosen by the bypass logic
  typedef enum logic [1:0] {
    REGFILE  = 2'b00,  // Value read at decode
    FROM_WB  = 2'b01,  // Result sitting in MEM/WB
    FROM_MEM = 2'b10   // ALU result sitting in EX/MEM
  } fwdSelT;

  typedef struct packed {
    opcodeT op;
    regIdT  rd;  // Store offset for SW
    regIdT  rs;
    regIdT  rt;  // Load offset for LW, low immediate nibble for LDI
  } instrT;

  typedef struct packed {
    opcodeT op;
    logic   valid;
    regIdT  rd;
    regIdT  rs;
    regIdT  rt;
    wordT   rdataA;
    wordT   rdataB;
    wordT   imm;  // Already zero extended at decode
  } idExT;

  typedef struct packed {
    opcodeT op;
    logic   valid;
    logic   regWrite;   // Qualified by valid and a nonzero rd
    regIdT  rd;
    regIdT  rt;         // Store data source, checked for MEM-to-MEM bypass
    wordT   aluResult;
    wordT   storeData;
  } exMemT;

  typedef struct packed {
    logic  valid;
    logic  regWrite;
    regIdT rd;
    wordT  result;
  } memWbT;

  typedef struct packed {
    logic  valid;
    regIdT rd;
    wordT  data;
  } wbBusT;

endpackage

// File: rtl/ForwardingUnit.sv
`timescale 1ns/1ns

module ForwardingUnit (
  input  cpuPkg::regIdT  exRs,         // First source of the instruction in EX
  input  cpuPkg::regIdT  exRt,         // Second source of the instruction in EX
  input  cpuPkg::regIdT  memRt,        // Store data register of the instruction in MEM
  input  cpuPkg::regIdT  memRd,        // Destination of the instruction in MEM
  input  cpuPkg::regIdT  wbRd,         // Destination of the instruction in WB
  input  logic           memRegWrite,  // MEM instruction writes a register
  input  logic           wbRegWrite,   // WB instruction writes a register
  output cpuPkg::fwdSelT fwdA,
  output cpuPkg::fwdSelT fwdB,
  output logic           fwdStoreEx,   // Store data in EX comes from WB
  output logic           fwdStoreMem   // Store data in MEM comes from WB
);
  import cpuPkg::*;

  logic memWrites;  // MEM stage holds a live write to a real register
  logic wbWrites;   // WB stage holds a live write to a real register
  logic exExHazA;
  logic exExHazB;
  logic memExHazA;
  logic memExHazB;

  // Register 0 is never a bypass source
  assign memWrites = memRegWrite && (memRd != '0);
  assign wbWrites  = wbRegWrite && (wbRd != '0);

  ////////////////////////////////
  // ALU operand bypass
  ////////////////////////////////

  assign exExHazA = memWrites && (memRd == exRs);  // Result one instruction ahead
  assign exExHazB = memWrites && (memRd == exRt);

  // The WB result is older, so it only counts when MEM has no match
  assign memExHazA = wbWrites && !exExHazA && (wbRd == exRs);
  assign memExHazB = wbWrites && !exExHazB && (wbRd == exRt);

  always_comb begin
    if (exExHazA) fwdA = FROM_MEM;
    else if (memExHazA) fwdA = FROM_WB;
    else fwdA = REGFILE;
  end

  always_comb begin
    if (exExHazB) fwdB = FROM_MEM;
    else if (memExHazB) fwdB = FROM_WB;
    else fwdB = REGFILE;
  end

  ////////////////////////////////
  // Store data bypass
  ////////////////////////////////

  // Store data in EX can be taken from the instruction two ahead
  assign fwdStoreEx = wbWrites && (wbRd == exRt);

  // A store right behind a load picks up the loaded word on its way to memory
  assign fwdStoreMem = wbWrites && (wbRd == memRt);

endmodule

// File: rtl/HazardDetection.sv
`timescale 1ns/1ns

module HazardDetection (
  input  cpuPkg::opcodeT inOp,      // Opcode of the instruction offered at intake
  input  cpuPkg::regIdT  inRs,
  input  cpuPkg::regIdT  inRt,
  input  logic           exIsLoad,  // Live LW sits in EX
  input  cpuPkg::regIdT  exRd,      // Target of that load
  output logic           stall
);
  import cpuPkg::*;

  logic readsRs;     // Incoming instruction needs rs in EX
  logic readsRt;     // Incoming instruction needs rt in EX
  logic loadLive;    // The load writes a real register
  logic rsConflict;
  logic rtConflict;

  // Loads and stores use rs as the address base
  assign readsRs = inOp inside {ADD, SUB, AND, XOR, LW, SW};

  // Only ALU ops need rt in EX, store data gets MEM-to-MEM bypass instead
  assign readsRt = inOp inside {ADD, SUB, AND, XOR};

  assign loadLive = exIsLoad && (exRd != '0);

  assign rsConflict = readsRs && (inRs == exRd);
  assign rtConflict = readsRt && (inRt == exRd);

  // Load data only exists at the end of MEM, so a dependent op waits a cycle
  assign stall = loadLive && (rsConflict || rtConflict);

endmodule

// File: rtl/RegisterFile.sv
`timescale 1ns/1ns

module RegisterFile (
  input  logic          clk,
  input  logic          rst,
  input  logic          we,
  input  cpuPkg::regIdT waddr,
  input  cpuPkg::regIdT raddrA,
  input  cpuPkg::regIdT raddrB,
  input  cpuPkg::wordT  wdata,
  output cpuPkg::wordT  rdataA,
  output cpuPkg::wordT  rdataB
);
  import cpuPkg::*;

  wordT regs [16];

  // Read one port, with register 0 tied low and the pending write passed through
  function automatic wordT readPort(input regIdT addr);
    if (addr == '0) begin
      return '0;
    end else if (we && (addr == waddr)) begin
      return wdata;  // Write-through so decode sees the result being retired
    end
    return regs[addr];
  endfunction

  ////////////////////////////////
  // Write port
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin  // Register 0 stays zero
      regs[waddr] <= wdata;
    end
  end

  ////////////////////////////////
  // Read ports
  ////////////////////////////////

  assign rdataA = readPort(raddrA);
  assign rdataB = readPort(raddrB);

endmodule

// File: rtl/AluUnit.sv
`timescale 1ns/1ns

module AluUnit (
  input  cpuPkg::opcodeT op,
  input  cpuPkg::wordT   a,       // First operand after bypass
  input  cpuPkg::wordT   b,       // Second operand after bypass
  input  cpuPkg::wordT   imm,     // Zero-extended immediate or offset
  output cpuPkg::wordT   result
);
  import cpuPkg::*;

  wordT sum;
  wordT diff;
  wordT addr;

  // All arithmetic wraps at 16 bits
  assign sum  = a + b;
  assign diff = a - b;

  // Address for LW and SW is base plus offset
  assign addr = a + imm;

  always_comb begin
    case (op)
      ADD: begin
        result = sum;
      end
      SUB: begin
        result = diff;
      end
      AND: begin
        result = a & b;
      end
      XOR: begin
        result = a ^ b;
      end
      LDI: begin
        result = imm;  // Immediate passes straight through
      end
      LW, SW: begin
        result = addr;
      end
      default: begin
        result = '0;  // NOP and unused codes
      end
    endcase
  end

endmodule

// File: rtl/DataMemory.sv
`timescale 1ns/1ns

module DataMemory #(
  parameter int depth = 256  // Number of words
) (
  input  logic            clk,
  input  logic            we,
  input  cpuPkg::memAddrT addr,
  input  cpuPkg::wordT    wdata,
  output cpuPkg::wordT    rdata
);
  import cpuPkg::*;

  wordT mem [depth];

  ////////////////////////////////
  // Storage
  ////////////////////////////////

  // Stores land at the clock edge that ends MEM
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Loads read within the same cycle so the word reaches MEM/WB on time
  assign rdata = mem[addr];

endmodule

// File: rtl/PipelineCore.sv
`timescale 1ns/1ns

module PipelineCore #(
  parameter int memDepth = 256
) (
  input  logic          clk,
  input  logic          rst,
  input  cpuPkg::instrT instr,
  input  logic          instrValid,
  output logic          instrReady,
  output cpuPkg::wbBusT wbBus
);
  import cpuPkg::*;

  idExT    idEx;
  exMemT   exMem;
  memWbT   memWb;
  opcodeT  hazOp;         // Intake opcode or NOP when nothing is offered
  logic    stall;
  logic    accept;        // Instruction taken at this edge
  wordT    rfA;
  wordT    rfB;
  wordT    decImm;
  fwdSelT  fwdA;
  fwdSelT  fwdB;
  logic    fwdStoreEx;
  logic    fwdStoreMem;
  wordT    opA;
  wordT    opB;
  wordT    aluOut;
  wordT    exStoreData;
  logic    exRegWrite;
  memAddrT memAddr;
  wordT    memStoreData;
  wordT    loadData;

  // Operand after bypass with the newest source first
  function automatic wordT bypass(input fwdSelT sel, input wordT regVal);
    case (sel)
      FROM_MEM: return exMem.aluResult;
      FROM_WB:  return memWb.result;
      default:  return regVal;
    endcase
  endfunction

  ////////////////////////////////
  // Intake and decode
  ////////////////////////////////

  assign hazOp      = instrValid ? instr.op : NOP;  // Idle intake never stalls
  assign instrReady = !stall;
  assign accept     = instrValid && !stall;

  HazardDetection hazard0 (
    .inOp(hazOp), .inRs(instr.rs), .inRt(instr.rt),
    .exIsLoad(idEx.valid && (idEx.op == LW)), .exRd(idEx.rd), .stall(stall)
  );

  RegisterFile regs0 (
    .clk(clk), .rst(rst), .we(memWb.valid && memWb.regWrite), .waddr(memWb.rd),
    .raddrA(instr.rs), .raddrB(instr.rt), .wdata(memWb.result),
    .rdataA(rfA), .rdataB(rfB)
  );

  always_comb begin
    case (instr.op)
      LDI:     decImm = {8'h00, instr.rs, instr.rt};  // Immediate spans both source fields
      LW:      decImm = {12'h000, instr.rt};
      SW:      decImm = {12'h000, instr.rd};
      default: decImm = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) idEx.valid <= 1'b0;
    else idEx.valid <= accept;  // A stall leaves a bubble here
  end

  always_ff @(posedge clk) begin
    idEx.op     <= instr.op;
    idEx.rd     <= instr.rd;
    idEx.rs     <= instr.rs;
    idEx.rt     <= instr.rt;
    idEx.rdataA <= rfA;
    idEx.rdataB <= rfB;
    idEx.imm    <= decImm;
  end

  ////////////////////////////////
  // Execute
  ////////////////////////////////

  ForwardingUnit fwd0 (
    .exRs(idEx.rs), .exRt(idEx.rt), .memRt(exMem.rt), .memRd(exMem.rd), .wbRd(memWb.rd),
    .memRegWrite(exMem.regWrite), .wbRegWrite(memWb.regWrite),
    .fwdA(fwdA), .fwdB(fwdB), .fwdStoreEx(fwdStoreEx), .fwdStoreMem(fwdStoreMem)
  );

  assign opA = bypass(fwdA, idEx.rdataA);
  assign opB = bypass(fwdB, idEx.rdataB);

  // Store data in EX takes the WB copy of rt and MEM fixes up a store right behind its producer
  assign exStoreData = fwdStoreEx ? memWb.result : idEx.rdataB;

  // Writes to register 0 and NOPs are dropped here and never reported
  assign exRegWrite = idEx.valid && (idEx.op inside {ADD, SUB, AND, XOR, LDI, LW}) &&
                      (idEx.rd != '0);

  AluUnit alu0 (.op(idEx.op), .a(opA), .b(opB), .imm(idEx.imm), .result(aluOut));

  always_ff @(posedge clk) begin
    if (rst) begin
      exMem.valid    <= 1'b0;
      exMem.regWrite <= 1'b0;
    end else begin
      exMem.valid    <= idEx.valid;
      exMem.regWrite <= exRegWrite;
    end
  end

  always_ff @(posedge clk) begin
    exMem.op        <= idEx.op;
    exMem.rd        <= idEx.rd;
    exMem.rt        <= idEx.rt;
    exMem.aluResult <= aluOut;
    exMem.storeData <= exStoreData;
  end

  ////////////////////////////////
  // Memory and writeback
  ////////////////////////////////

  assign memAddr      = exMem.aluResult[7:0];
  assign memStoreData = fwdStoreMem ? memWb.result : exMem.storeData;  // Load then store

  DataMemory #(.depth(memDepth)) dmem0 (
    .clk(clk), .we(exMem.valid && (exMem.op == SW)), .addr(memAddr),
    .wdata(memStoreData), .rdata(loadData)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      memWb.valid    <= 1'b0;
      memWb.regWrite <= 1'b0;
    end else begin
      memWb.valid    <= exMem.valid;
      memWb.regWrite <= exMem.regWrite;
    end
  end

  always_ff @(posedge clk) begin
    memWb.rd     <= exMem.rd;
    memWb.result <= (exMem.op == LW) ? loadData : exMem.aluResult;
  end

  // Every register write is reported in the cycle before it lands
  assign wbBus.valid = memWb.valid && memWb.regWrite;
  assign wbBus.rd    = memWb.rd;
  assign wbBus.data  = memWb.result;

endmodule

// File: bench/coreModel.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// One expected writeback report
typedef struct packed {
  regIdT rd;
  wordT  data;
} reportT;

wordT   modelRegs [16];  // Architectural register state
wordT   modelMem [256];  // Architectural data memory
reportT expectQ [$];     // Reports still owed by the DUT, oldest first
logic   queueFilled;
regIdT  headRd;          // Copy of the queue head for the clocked check
wordT   headData;
int     reportsExpected;

//////////////////////////////
// Instruction encoding
//////////////////////////////

function automatic instrT encode(input opcodeT op, input regIdT rd, input regIdT rs,
                                 input regIdT rt);
  instrT ins;
  ins.op = op;
  ins.rd = rd;
  ins.rs = rs;
  ins.rt = rt;
  return ins;
endfunction

// The 8-bit immediate is split across the two source fields
function automatic instrT encLdi(input regIdT rd, input logic [7:0] imm);
  return encode(LDI, rd, imm[7:4], imm[3:0]);
endfunction

function automatic instrT encLw(input regIdT rd, input regIdT base, input regIdT off);
  return encode(LW, rd, base, off);
endfunction

// Store offset sits where a destination would be
function automatic instrT encSw(input regIdT base, input regIdT off, input regIdT src);
  return encode(SW, off, base, src);
endfunction

//////////////////////////////
// Architectural model
//////////////////////////////

// Register result of an instruction against the current model state
function automatic wordT expectedResult(input instrT ins);
  wordT a;
  wordT b;
  wordT addrSum;
  a = modelRegs[ins.rs];  // Entry 0 is never written so it reads zero
  b = modelRegs[ins.rt];
  case (ins.op)
    ADD: return a + b;
    SUB: return a - b;
    AND: return a & b;
    XOR: return a ^ b;
    LDI: return {8'h00, ins.rs, ins.rt};
    LW: begin
      addrSum = a + {12'h000, ins.rt};
      return modelMem[addrSum[7:0]];  // Only the low byte addresses memory
    end
    default: return '0;
  endcase
endfunction

function automatic void refreshHead();
  queueFilled = (expectQ.size() != 0);
  if (queueFilled) begin
    headRd   = expectQ[0].rd;
    headData = expectQ[0].data;
  end
endfunction

// Retire one accepted instruction in program order
function automatic void modelExecute(input instrT ins);
  wordT   value;
  wordT   addrSum;
  reportT rep;
  value = expectedResult(ins);
  case (ins.op)
    ADD, SUB, AND, XOR, LDI, LW: begin
      if (ins.rd != 4'd0) begin  // Writes to register 0 vanish without a report
        modelRegs[ins.rd] = value;
        rep.rd = ins.rd;
        rep.data = value;
        expectQ.push_back(rep);
        reportsExpected++;
      end
    end
    SW: begin
      addrSum = modelRegs[ins.rs] + {12'h000, ins.rd};
      modelMem[addrSum[7:0]] = modelRegs[ins.rt];
    end
    default: begin
    end
  endcase
  refreshHead();
endfunction

`endif

// File: bench/coreTb.sv
`timescale 1ns/1ns

module coreTb;
  import cpuPkg::*;

  `include "coreModel.svh"

  logic  clk;
  logic  rst;
  instrT instr;
  logic  instrValid;
  logic  instrReady;
  wbBusT wbBus;

  int   seed;
  int   errorCount;
  int   testsPassed;
  int   testsFailed;
  int   reportsSeen;
  int   lastStalls;         // Cycles the last instruction waited on instrReady
  logic popPending = 1'b0;  // Report seen mid-cycle, retired at the next edge
  event abortRun;

  PipelineCore #(.memDepth(256)) dut0 (
    .clk(clk), .rst(rst), .instr(instr), .instrValid(instrValid),
    .instrReady(instrReady), .wbBus(wbBus)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // A hung handshake or a missing report ends the run here
  initial begin
    @(abortRun);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////
  // Writeback checking
  //////////////////////////////

  // wbBus and the queue head are both stable at the falling edge
  property reportMatchesModel;
    @(negedge clk) disable iff (rst)
      wbBus.valid |-> (queueFilled && (wbBus.rd == headRd) && (wbBus.data == headData));
  endproperty

  checkReport: assert property (reportMatchesModel)
    else begin
      errorCount++;
      if (!queueFilled) begin
        $display("Unexpected writeback report at %0t with no instruction outstanding", $time);
      end else if (wbBus.rd != headRd) begin
        $display("ERROR t=%0t wbBus.rd got %0d expected %0d", $time, wbBus.rd, headRd);
      end else begin
        $display("ERROR t=%0t wbBus.data got %h expected %h", $time, wbBus.data, headData);
      end
    end

  quietInReset: assert property (@(negedge clk) rst |-> !wbBus.valid)
    else begin
      errorCount++;
      $display("ERROR t=%0t wbBus.valid got %b expected 0 in reset", $time, wbBus.valid);
    end

  always @(negedge clk) popPending = !rst && wbBus.valid;

  always @(posedge clk) begin
    if (popPending) begin
      reportsSeen++;
      if (expectQ.size() != 0) expectQ.delete(0);
      refreshHead();
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic send(input instrT ins);
    logic rdy;
    int   waited;
    rdy = 1'b0;
    waited = 0;
    instr = ins;
    instrValid = 1'b1;
    while (!rdy) begin
      @(negedge clk);
      rdy = instrReady;
      @(posedge clk);
      if (!rdy) begin
        waited++;
        if (waited > 8) begin
          $display("Timeout: instrReady stayed low for %0d cycles", waited);
          -> abortRun;
        end
      end
    end
    #1;
    lastStalls = waited;
    modelExecute(ins);
  endtask

  task automatic idleCycles(input int n);
    instrValid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drainReports();
    int waited;
    instrValid = 1'b0;
    waited = 0;
    while ((expectQ.size() != 0) && (waited < 20)) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (expectQ.size() != 0) begin
      $display("Timeout: %0d writeback reports never appeared", expectQ.size());
      -> abortRun;
    end
    idleCycles(3);  // A stray late report still gets caught here
  endtask

  task automatic endTest(input string name, input int errorsBefore);
    int found;
    drainReports();
    found = errorCount - errorsBefore;
    if (found == 0) begin
      testsPassed++;
      $display("%s: passed", name);
    end else begin
      testsFailed++;
      $display("%s: failed with %0d errors", name, found);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic testExForwarding();
    int errorsBefore;
    errorsBefore = errorCount;
    send(encLdi(4'd1, 8'h03));
    send(encLdi(4'd2, 8'h05));
    send(encLdi(4'd3, 8'h10));
    send(encLdi(4'd4, 8'hF0));
    send(encode(ADD, 4'd5, 4'd1, 4'd2));
    send(encode(SUB, 4'd6, 4'd5, 4'd3));  // Previous result on rs
    send(encode(XOR, 4'd7, 4'd4, 4'd6));  // Previous result on rt
    send(encode(AND, 4'd8, 4'd7, 4'd7));
    send(encode(ADD, 4'd9, 4'd8, 4'd8));
    send(encode(SUB, 4'd10, 4'd1, 4'd9)); // Wraps below zero
    endTest("EX-to-EX forwarding", errorsBefore);
  endtask

  task automatic testWbPriority();
    int errorsBefore;
    errorsBefore = errorCount;
    send(encLdi(4'd1, 8'h11));
    send(encLdi(4'd1, 8'h22));
    send(encode(ADD, 4'd2, 4'd1, 4'd1));  // Newer write of r1 must win
    send(encode(ADD, 4'd3, 4'd1, 4'd2));  // r1 now comes from WB, r2 from MEM
    endTest("MEM-to-EX forwarding and priority", errorsBefore);
  endtask

  task automatic testRegisterZero();
    int errorsBefore;
    errorsBefore = errorCount;
    send(encLdi(4'd0, 8'h55));
    send(encLdi(4'd1, 8'h07));
    send(encode(ADD, 4'd0, 4'd1, 4'd1));
    send(encode(ADD, 4'd2, 4'd0, 4'd1));  // Nothing may be bypassed from r0
    send(encode(XOR, 4'd3, 4'd1, 4'd0));
    endTest("Register 0", errorsBefore);
  endtask

  task automatic testLoadUse();
    int errorsBefore;
    errorsBefore = errorCount;
    send(encLdi(4'd1, 8'h50));
    send(encLdi(4'd2, 8'h0A));
    send(encSw(4'd1, 4'd3, 4'd2));
    send(encLw(4'd3, 4'd1, 4'd3));
    send(encode(ADD, 4'd4, 4'd3, 4'd2));
    assert (lastStalls == 1)
      else begin
        errorCount++;
        $display("ERROR t=%0t instrReady low cycles got %0d expected 1", $time, lastStalls);
      end
    endTest("Load-use stall", errorsBefore);
  endtask

  task automatic testStoreForwarding();
    int errorsBefore;
    errorsBefore = errorCount;
    send(encLdi(4'd10, 8'h40));
    send(encLdi(4'd11, 8'h12));
    send(encode(ADD, 4'd12, 4'd11, 4'd11));
    send(encSw(4'd10, 4'd2, 4'd12));      // ALU result straight into a store
    send(encLw(4'd13, 4'd10, 4'd2));
    send(encSw(4'd10, 4'd5, 4'd13));      // Loaded word straight into a store
    idleCycles(2);
    send(encLw(4'd14, 4'd10, 4'd2));
    send(encLw(4'd15, 4'd10, 4'd5));
    endTest("Store data forwarding", errorsBefore);
  endtask

  task automatic testRandomStream();
    int    errorsBefore;
    int    seenBefore;
    int    expectedBefore;
    regIdT d;
    regIdT s;
    regIdT t;
    errorsBefore = errorCount;
    seenBefore = reportsSeen;
    expectedBefore = reportsExpected;
    // r7 is the fixed base, so every access lands in 0x20 to 0x2F
    send(encLdi(4'd7, 8'h20));
    for (int i = 0; i < 16; i++) begin
      send(encLdi(4'd1, 8'(i * 13 + 5)));
      send(encSw(4'd7, 4'(i), 4'd1));
    end
    for (int n = 0; n < 300; n++) begin
      d = 4'(1 + pick(6));
      s = 4'(1 + pick(7));
      t = 4'(1 + pick(7));
      case (pick(7))
        0: send(encode(ADD, d, s, t));
        1: send(encode(SUB, d, s, t));
        2: send(encode(AND, d, s, t));
        3: send(encode(XOR, d, s, t));
        4: send(encLdi(d, 8'(pick(256))));
        5: send(encLw(d, 4'd7, 4'(pick(16))));
        default: send(encSw(4'd7, 4'(pick(16)), s));
      endcase
      if (pick(4) == 0) idleCycles(1 + pick(2));
    end
    drainReports();
    assert ((reportsSeen - seenBefore) == (reportsExpected - expectedBefore))
      else begin
        errorCount++;
        $display("ERROR t=%0t report count got %0d expected %0d", $time,
                 reportsSeen - seenBefore, reportsExpected - expectedBefore);
      end
    endTest("Random stream", errorsBefore);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed = 76231;
    rst = 1'b1;
    instr = encode(NOP, 4'd0, 4'd0, 4'd0);
    instrValid = 1'b0;
    errorCount = 0;
    testsPassed = 0;
    testsFailed = 0;
    reportsSeen = 0;
    reportsExpected = 0;
    lastStalls = 0;
    for (int i = 0; i < 16; i++) modelRegs[i] = '0;
    for (int i = 0; i < 256; i++) modelMem[i] = '0;
    refreshHead();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    testExForwarding();
    testWbPriority();
    testRegisterZero();
    testLoadUse();
    testStoreForwarding();
    testRandomStream();
    $display("Tests passed %0d failed %0d", testsPassed, testsFailed);
    if ((testsFailed == 0) && (errorCount == 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+bench
rtl/cpuPkg.sv
rtl/ForwardingUnit.sv
rtl/HazardDetection.sv
rtl/RegisterFile.sv
rtl/AluUnit.sv
rtl/DataMemory.sv
rtl/PipelineCore.sv
bench/coreTb.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := coreTb
FILELIST := sim.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(wildcard rtl/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

.PHONY: all run check clean

all: check

# Rebuilt only when a source file or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@grep -q "^TEST RESULT: PASS$$" $(LOG) && echo "Simulation passed" || \
	  (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
